// File: lc3b_types.sv
package lc3b_types;

//////////////////////////////////////////////////////////////////////
// machine word.
//////////////////////////////////////////////////////////////////////

typedef logic [15:0] lc3b_word;

//////////////////////////////////////////////////////////////////////
// btb geometry.
//////////////////////////////////////////////////////////////////////

localparam int BTB_WAYS       = 4;
localparam int BTB_SETS       = 8;
localparam int BTB_INDEX_BITS = 3;
localparam int BTB_TAG_BITS   = 12;

// pc bit 0 is always zero, so the index starts at bit 1.
localparam int BTB_INDEX_LSB  = 1;
localparam int BTB_TAG_LSB    = BTB_INDEX_LSB + BTB_INDEX_BITS;

typedef logic [BTB_INDEX_BITS-1:0] btb_index_t;
typedef logic [BTB_TAG_BITS-1:0]   btb_tag_t;
typedef logic [1:0]                btb_way_t;

// one way of a set, 29 bits.
typedef struct packed {
    logic     valid;
    btb_tag_t tag;
    lc3b_word target;
} btb_entry_t;

// a full set row as stored in the entry memory.
typedef btb_entry_t [BTB_WAYS-1:0] btb_set_t;

// tree pseudo-lru state for one set.
// root low means the victim sits in ways 0 and 1.
typedef struct packed {
    logic root;
    logic left;
    logic right;
} plru_t;

endpackage : lc3b_types

// File: btb_set_mem.sv
`timescale 1ns/100ps

module btb_set_mem
    import lc3b_types::*;
#(
    parameter type payload_t = btb_set_t
)
(
    input  logic       clk,
    input  logic       rst,

    // lookup side read.
    input  btb_index_t rd_index_a,
    output payload_t   rd_data_a,

    // update side read.
    input  btb_index_t rd_index_b,
    output payload_t   rd_data_b,

    // single write port.
    input  logic       we,
    input  btb_index_t windex,
    input  payload_t   wdata
);

//////////////////////////////////////////////////////////////////////
// row storage.
//////////////////////////////////////////////////////////////////////

payload_t rows [BTB_SETS];

always_ff @(posedge clk) begin
    if (rst) begin
        for (int i = 0; i < BTB_SETS; i++) begin
            rows[i] <= '0;
        end
    end else if (we) begin
        rows[windex] <= wdata;
    end
end

//////////////////////////////////////////////////////////////////////
// read ports, both combinational.
//////////////////////////////////////////////////////////////////////

// a write only shows up after the edge.
assign rd_data_a = rows[rd_index_a];
assign rd_data_b = rows[rd_index_b];

endmodule : btb_set_mem

// File: lru_logic.sv
`timescale 1ns/100ps

module lru_logic
    import lc3b_types::*;
(
    input  plru_t    lru_in,
    input  btb_way_t touch_way,

    output btb_way_t victim,
    output plru_t    lru_out
);

//////////////////////////////////////////////////////////////////////
// victim choice.
//////////////////////////////////////////////////////////////////////

// root picks the half, the lower node picks the way in it.
always_comb begin
    if (!lru_in.root) begin
        victim = {1'b0, lru_in.left};
    end else begin
        victim = {1'b1, lru_in.right};
    end
end

//////////////////////////////////////////////////////////////////////
// touch update.
//////////////////////////////////////////////////////////////////////

// point every node on the path away from the touched way.
// the node of the other half keeps its value.
always_comb begin
    lru_out = lru_in;
    if (!touch_way[1]) begin
        lru_out.root = 1'b1;
        lru_out.left = ~touch_way[0];
    end else begin
        lru_out.root  = 1'b0;
        lru_out.right = ~touch_way[0];
    end
end

endmodule : lru_logic

// File: branch_logic.sv
`timescale 1ns/100ps

module branch_logic
    import lc3b_types::*;
(
    // fetch side.
    input  logic       fetch_valid,
    input  lc3b_word   fetch_pc,
    output btb_index_t lookup_index,
    input  btb_set_t   lookup_set,
    input  plru_t      lookup_lru,
    output logic       predict_hit,
    output lc3b_word   predict_target,

    // execute side.
    input  logic       update_valid,
    input  lc3b_word   update_pc,
    input  lc3b_word   update_target,
    output btb_index_t update_index,
    input  btb_set_t   update_set,
    input  plru_t      update_lru,

    // store writes.
    output logic       set_we,
    output btb_index_t set_windex,
    output btb_set_t   set_wdata,
    output logic       lru_we,
    output btb_index_t lru_windex,
    output plru_t      lru_wdata
);

btb_tag_t lookup_tag;
btb_tag_t update_tag;

logic     lookup_match;
btb_way_t hit_way;
lc3b_word hit_target;
plru_t    lookup_touch;

logic     update_match;
btb_way_t match_way;
logic     update_free;
btb_way_t free_way;
btb_way_t update_victim;
btb_way_t write_way;
plru_t    update_touch;

assign lookup_index = fetch_pc[BTB_TAG_LSB-1:BTB_INDEX_LSB];
assign lookup_tag   = fetch_pc[15:BTB_TAG_LSB];
assign update_index = update_pc[BTB_TAG_LSB-1:BTB_INDEX_LSB];
assign update_tag   = update_pc[15:BTB_TAG_LSB];

//////////////////////////////////////////////////////////////////////
// lookup.
//////////////////////////////////////////////////////////////////////

// walk down so the lowest matching way is left standing.
always_comb begin
    lookup_match = 1'b0;
    hit_way      = '0;
    hit_target   = '0;
    for (int w = BTB_WAYS - 1; w >= 0; w--) begin
        if (lookup_set[w].valid && lookup_set[w].tag == lookup_tag) begin
            lookup_match = 1'b1;
            hit_way      = btb_way_t'(w);
            hit_target   = lookup_set[w].target;
        end
    end
end

assign predict_hit    = fetch_valid & lookup_match;
assign predict_target = predict_hit ? hit_target : '0;

lru_logic lookup_lru_i
(
    .lru_in(lookup_lru),
    .touch_way(hit_way),
    .victim(),
    .lru_out(lookup_touch)
);

//////////////////////////////////////////////////////////////////////
// update way choice.
//////////////////////////////////////////////////////////////////////

always_comb begin
    update_match = 1'b0;
    match_way    = '0;
    update_free  = 1'b0;
    free_way     = '0;
    for (int w = BTB_WAYS - 1; w >= 0; w--) begin
        if (update_set[w].valid && update_set[w].tag == update_tag) begin
            update_match = 1'b1;
            match_way    = btb_way_t'(w);
        end
        if (!update_set[w].valid) begin
            update_free = 1'b1;
            free_way    = btb_way_t'(w);
        end
    end
end

// an existing entry keeps its way, then fill a hole, then evict.
always_comb begin
    if (update_match) begin
        write_way = match_way;
    end else if (update_free) begin
        write_way = free_way;
    end else begin
        write_way = update_victim;
    end
end

lru_logic update_lru_i
(
    .lru_in(update_lru),
    .touch_way(write_way),
    .victim(update_victim),
    .lru_out(update_touch)
);

//////////////////////////////////////////////////////////////////////
// store writes.
//////////////////////////////////////////////////////////////////////

always_comb begin
    set_wdata = update_set;
    set_wdata[write_way] = '{valid: 1'b1, tag: update_tag, target: update_target};
end

assign set_we     = update_valid;
assign set_windex = update_index;

// one lru port, the update touch takes it over a lookup hit.
assign lru_we     = update_valid | predict_hit;
assign lru_windex = update_valid ? update_index : lookup_index;
assign lru_wdata  = update_valid ? update_touch : lookup_touch;

endmodule : branch_logic

// File: btb_top.sv
`timescale 1ns/100ps

module btb_top
    import lc3b_types::*;
(
    input  logic     clk,
    input  logic     rst,

    input  logic     fetch_valid,
    input  lc3b_word fetch_pc,
    output logic     predict_hit,
    output lc3b_word predict_target,

    input  logic     update_valid,
    input  lc3b_word update_pc,
    input  lc3b_word update_target
);

btb_index_t lookup_index;
btb_index_t update_index;
btb_set_t   lookup_set;
btb_set_t   update_set;
plru_t      lookup_lru;
plru_t      update_lru;

logic       set_we;
btb_index_t set_windex;
btb_set_t   set_wdata;
logic       lru_we;
btb_index_t lru_windex;
plru_t      lru_wdata;

//////////////////////////////////////////////////////////////////////
// storage.
//////////////////////////////////////////////////////////////////////

btb_set_mem #(.payload_t(btb_set_t)) entry_mem_i
(
    .clk(clk),
    .rst(rst),
    .rd_index_a(lookup_index),
    .rd_data_a(lookup_set),
    .rd_index_b(update_index),
    .rd_data_b(update_set),
    .we(set_we),
    .windex(set_windex),
    .wdata(set_wdata)
);

btb_set_mem #(.payload_t(plru_t)) lru_mem_i
(
    .clk(clk),
    .rst(rst),
    .rd_index_a(lookup_index),
    .rd_data_a(lookup_lru),
    .rd_index_b(update_index),
    .rd_data_b(update_lru),
    .we(lru_we),
    .windex(lru_windex),
    .wdata(lru_wdata)
);

//////////////////////////////////////////////////////////////////////
// lookup and update control.
//////////////////////////////////////////////////////////////////////

branch_logic logic_i
(
    .fetch_valid(fetch_valid),
    .fetch_pc(fetch_pc),
    .lookup_index(lookup_index),
    .lookup_set(lookup_set),
    .lookup_lru(lookup_lru),
    .predict_hit(predict_hit),
    .predict_target(predict_target),
    .update_valid(update_valid),
    .update_pc(update_pc),
    .update_target(update_target),
    .update_index(update_index),
    .update_set(update_set),
    .update_lru(update_lru),
    .set_we(set_we),
    .set_windex(set_windex),
    .set_wdata(set_wdata),
    .lru_we(lru_we),
    .lru_windex(lru_windex),
    .lru_wdata(lru_wdata)
);

endmodule : btb_top

// File: btb_properties.sv
`timescale 1ns/100ps

module btb_properties
    import lc3b_types::*;
(
    input logic     clk,
    input logic     rst,
    input logic     fetch_valid,
    input logic     predict_hit,
    input lc3b_word predict_target
);

hit_needs_fetch: assert property (@(posedge clk) disable iff (rst)
    predict_hit |-> fetch_valid)
    else $error("predict_hit high while fetch_valid is low");

// a miss never leaks a stale target.
miss_target_zero: assert property (@(posedge clk) disable iff (rst)
    !predict_hit |-> predict_target == 16'h0)
    else $error("predict_target not zero on a miss");

miss_after_reset: assert property (@(posedge clk)
    rst |=> !predict_hit)
    else $error("predict_hit high in the cycle after reset");

endmodule : btb_properties

bind btb_top btb_properties props_i (
    .clk(clk),
    .rst(rst),
    .fetch_valid(fetch_valid),
    .predict_hit(predict_hit),
    .predict_target(predict_target)
);

// File: tb_btb.sv
`timescale 1ns/100ps

module tb_btb
    import lc3b_types::*;
();

localparam int CYCLE_LIMIT = 2000;

logic     clk;
logic     rst;
logic     fetch_valid;
lc3b_word fetch_pc;
logic     predict_hit;
lc3b_word predict_target;
logic     update_valid;
lc3b_word update_pc;
lc3b_word update_target;

// reference model state with plru bits ordered {root, left, right}.
logic       m_valid  [BTB_SETS][BTB_WAYS];
btb_tag_t   m_tag    [BTB_SETS][BTB_WAYS];
lc3b_word   m_target [BTB_SETS][BTB_WAYS];
logic [2:0] m_plru   [BTB_SETS];

integer   seed;
int       cycle_count = 0;
logic     seen_hit;
lc3b_word seen_target;

btb_top dut_i (
    .clk(clk),
    .rst(rst),
    .fetch_valid(fetch_valid),
    .fetch_pc(fetch_pc),
    .predict_hit(predict_hit),
    .predict_target(predict_target),
    .update_valid(update_valid),
    .update_pc(update_pc),
    .update_target(update_target)
);

initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
end

always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
        $display("SOME TESTS FAILED");
        $fatal(1, "timeout: simulation ran too long");
    end
end

//////////////////////////////////////////////////////////////////////
// reference model.
//////////////////////////////////////////////////////////////////////

function automatic btb_way_t plru_victim_of(input logic [2:0] state);
    if (!state[2]) begin
        return {1'b0, state[1]};
    end
    return {1'b1, state[0]};
endfunction

// the touched way's path points the other way afterwards.
function automatic logic [2:0] plru_after_touch(input logic [2:0] state, input btb_way_t way);
    logic [2:0] result;
    result = state;
    if (!way[1]) begin
        result[2] = 1'b1;
        result[1] = ~way[0];
    end else begin
        result[2] = 1'b0;
        result[0] = ~way[0];
    end
    return result;
endfunction

function automatic lc3b_word make_pc(input btb_tag_t tag, input btb_index_t idx);
    return {tag, idx, 1'b0};
endfunction

task automatic model_reset();
    for (int s = 0; s < BTB_SETS; s++) begin
        for (int w = 0; w < BTB_WAYS; w++) begin
            m_valid[s][w]  = 1'b0;
            m_tag[s][w]    = '0;
            m_target[s][w] = '0;
        end
        m_plru[s] = 3'b000;
    end
endtask

task automatic model_lookup(input lc3b_word pc, output logic hit, output btb_way_t way,
                            output lc3b_word target);
    btb_index_t idx;
    btb_tag_t   tag;
    idx    = pc[3:1];
    tag    = pc[15:4];
    hit    = 1'b0;
    way    = '0;
    target = '0;
    for (int w = 0; w < BTB_WAYS; w++) begin
        if (!hit && m_valid[idx][w] && m_tag[idx][w] == tag) begin
            hit    = 1'b1;
            way    = btb_way_t'(w);
            target = m_target[idx][w];
        end
    end
endtask

task automatic model_update(input lc3b_word pc, input lc3b_word target);
    btb_index_t idx;
    btb_tag_t   tag;
    logic       found;
    btb_way_t   way;
    idx   = pc[3:1];
    tag   = pc[15:4];
    found = 1'b0;
    way   = '0;
    for (int w = 0; w < BTB_WAYS; w++) begin
        if (!found && m_valid[idx][w] && m_tag[idx][w] == tag) begin
            found = 1'b1;
            way   = btb_way_t'(w);
        end
    end
    for (int w = 0; w < BTB_WAYS; w++) begin
        if (!found && !m_valid[idx][w]) begin
            found = 1'b1;
            way   = btb_way_t'(w);
        end
    end
    if (!found) begin
        way = plru_victim_of(m_plru[idx]);
    end
    m_valid[idx][way]  = 1'b1;
    m_tag[idx][way]    = tag;
    m_target[idx][way] = target;
    m_plru[idx]        = plru_after_touch(m_plru[idx], way);
endtask

//////////////////////////////////////////////////////////////////////
// drive and check.
//////////////////////////////////////////////////////////////////////

task automatic check_value(input string what, input lc3b_word expected, input lc3b_word actual);
    if (actual !== expected) begin
        $display("** Error at %0d ns: %s expected %h, got %h", $time, what, expected, actual);
        $display("SOME TESTS FAILED");
        $fatal(1, "value mismatch");
    end
endtask

// entered 10 ns after a rising edge and left at the same point one cycle on.
task automatic run_cycle(input logic fv, input lc3b_word fpc, input logic uv,
                         input lc3b_word upc, input lc3b_word utgt);
    logic     exp_hit;
    btb_way_t exp_way;
    lc3b_word exp_target;
    fetch_valid   = fv;
    fetch_pc      = fpc;
    update_valid  = uv;
    update_pc     = upc;
    update_target = utgt;
    #80;
    model_lookup(fpc, exp_hit, exp_way, exp_target);
    exp_hit = exp_hit & fv;
    if (!exp_hit) begin
        exp_target = '0;
    end
    seen_hit    = predict_hit;
    seen_target = predict_target;
    check_value("predict_hit", {15'd0, exp_hit}, {15'd0, predict_hit});
    check_value("predict_target", exp_target, predict_target);
    // the update owns the lru write port whenever it is active.
    if (uv) begin
        model_update(upc, utgt);
    end else if (exp_hit) begin
        m_plru[fpc[3:1]] = plru_after_touch(m_plru[fpc[3:1]], exp_way);
    end
    @(posedge clk);
    #10;
endtask

task automatic expect_lookup(input lc3b_word pc, input logic hit, input lc3b_word target);
    run_cycle(1'b1, pc, 1'b0, 16'h0, 16'h0);
    check_value("directed hit", {15'd0, hit}, {15'd0, seen_hit});
    check_value("directed target", target, seen_target);
endtask

task automatic do_update(input lc3b_word pc, input lc3b_word target);
    run_cycle(1'b0, 16'h0, 1'b1, pc, target);
endtask

// small pool of tags over sets 0 to 2 keeps the ways under pressure.
task automatic random_cycle();
    logic [31:0] strobes;
    lc3b_word    fpc;
    lc3b_word    upc;
    lc3b_word    utgt;
    strobes = $random(seed);
    fpc     = make_pc(btb_tag_t'(12'h040 + {$random(seed)} % 6),
                      btb_index_t'({$random(seed)} % 3));
    upc     = make_pc(btb_tag_t'(12'h040 + {$random(seed)} % 6),
                      btb_index_t'({$random(seed)} % 3));
    utgt    = lc3b_word'($random(seed));
    run_cycle(strobes[7], fpc, strobes[13], upc, utgt);
endtask

//////////////////////////////////////////////////////////////////////
// test sequence.
//////////////////////////////////////////////////////////////////////

initial begin
    seed          = 2;
    rst           = 1'b1;
    fetch_valid   = 1'b0;
    fetch_pc      = '0;
    update_valid  = 1'b0;
    update_pc     = '0;
    update_target = '0;
    seen_hit      = 1'b0;
    seen_target   = '0;
    model_reset();
    repeat (4) @(posedge clk);
    #10;
    rst = 1'b0;

    // empty after reset.
    for (int i = 0; i < BTB_SETS; i++) begin
        expect_lookup(make_pc(btb_tag_t'($random(seed)), btb_index_t'(i)), 1'b0, 16'h0);
    end

    // single entry followed by a different set and a different tag.
    do_update(16'h1234, 16'hbeef);
    expect_lookup(16'h1234, 1'b1, 16'hbeef);
    expect_lookup(16'h1236, 1'b0, 16'h0);
    expect_lookup(16'h2234, 1'b0, 16'h0);

    // retarget in a full set while a lookup in the same cycle sees the old target.
    do_update(make_pc(12'h011, 3'd1), 16'h1100);
    do_update(make_pc(12'h012, 3'd1), 16'h1200);
    do_update(make_pc(12'h013, 3'd1), 16'h1300);
    do_update(make_pc(12'h014, 3'd1), 16'h1400);
    run_cycle(1'b1, make_pc(12'h012, 3'd1), 1'b1, make_pc(12'h012, 3'd1), 16'h2200);
    check_value("old target", 16'h1200, seen_target);
    expect_lookup(make_pc(12'h012, 3'd1), 1'b1, 16'h2200);
    expect_lookup(make_pc(12'h011, 3'd1), 1'b1, 16'h1100);
    expect_lookup(make_pc(12'h013, 3'd1), 1'b1, 16'h1300);
    expect_lookup(make_pc(12'h014, 3'd1), 1'b1, 16'h1400);

    // fill and touch ways 0 and 2 so that way 1 becomes the victim.
    do_update(make_pc(12'h021, 3'd5), 16'h2100);
    do_update(make_pc(12'h022, 3'd5), 16'h2200);
    do_update(make_pc(12'h023, 3'd5), 16'h2300);
    do_update(make_pc(12'h024, 3'd5), 16'h2400);
    expect_lookup(make_pc(12'h021, 3'd5), 1'b1, 16'h2100);
    expect_lookup(make_pc(12'h023, 3'd5), 1'b1, 16'h2300);
    do_update(make_pc(12'h025, 3'd5), 16'h2500);
    expect_lookup(make_pc(12'h022, 3'd5), 1'b0, 16'h0);
    expect_lookup(make_pc(12'h021, 3'd5), 1'b1, 16'h2100);
    expect_lookup(make_pc(12'h023, 3'd5), 1'b1, 16'h2300);
    expect_lookup(make_pc(12'h024, 3'd5), 1'b1, 16'h2400);
    expect_lookup(make_pc(12'h025, 3'd5), 1'b1, 16'h2500);

    // the update touch of way 0 wins over the hit on way 2 and way 2 goes.
    do_update(make_pc(12'h031, 3'd6), 16'h3100);
    do_update(make_pc(12'h032, 3'd6), 16'h3200);
    do_update(make_pc(12'h033, 3'd6), 16'h3300);
    do_update(make_pc(12'h034, 3'd6), 16'h3400);
    run_cycle(1'b1, make_pc(12'h033, 3'd6), 1'b1, make_pc(12'h031, 3'd6), 16'h3111);
    check_value("same set hit", 16'h0001, {15'd0, seen_hit});
    do_update(make_pc(12'h035, 3'd6), 16'h3500);
    expect_lookup(make_pc(12'h033, 3'd6), 1'b0, 16'h0);
    expect_lookup(make_pc(12'h032, 3'd6), 1'b1, 16'h3200);
    expect_lookup(make_pc(12'h031, 3'd6), 1'b1, 16'h3111);
    expect_lookup(make_pc(12'h034, 3'd6), 1'b1, 16'h3400);
    expect_lookup(make_pc(12'h035, 3'd6), 1'b1, 16'h3500);

    for (int n = 0; n < 1000; n++) begin
        random_cycle();
    end

    $display("ALL TESTS PASSED");
    $finish;
end

endmodule : tb_btb

// File: src.f
lc3b_types.sv
btb_set_mem.sv
lru_logic.sv
branch_logic.sv
btb_top.sv
btb_properties.sv
tb_btb.sv

// File: run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_btb -f src.f -o sim_btb &&
./obj_dir/sim_btb || exit 1
